// File: bench/ntm_controller_tb.sv
// Testbench for the NTM controller hidden layer
// Commands and expected outputs come from bench/ntm_stimulus.txt
// Path is relative to the project root
// B stages a bias that goes out with the next driven cycle (T or first idle of I)
// Each h_valid is also checked to come exactly 3 cycles after its neuron's last term

`timescale 1ns/1ps

module ntm_controller_tb
  import ntm_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;

  ////////////////////////////////////////////////////////////
  // DUT signals and bench state
  ////////////////////////////////////////////////////////////

  logic        CLK;
  logic        RST;
  logic        term_valid;
  ntm_term_t   term;
  logic        bias_valid;
  data_t       bias;
  logic        h_valid;
  ntm_hidden_t h;

  // Parsed command stream
  byte         cmd_q[$];
  logic [31:0] arg0_q[$];
  logic [31:0] arg1_q[$];
  logic [31:0] arg2_q[$];
  logic [31:0] arg3_q[$];

  ntm_hidden_t expect_q[$];
  int          last_cycle_q[$];   // cycle of each closing last term

  int    cycle         = 0;
  int    cycle_limit   = 100000;
  int    n_lines       = 0;
  int    idle_total    = 0;
  int    value_errors  = 0;
  int    timing_errors = 0;
  int    other_errors  = 0;

  logic  pend_bias_valid;
  data_t pend_bias;
  logic  frame_open;              // bench view of neuron framing

  ntm_controller #(
    .FRAC_BITS(8)
  ) i_ntm_controller (
    .CLK       (CLK),
    .RST       (RST),
    .term_valid(term_valid),
    .term      (term),
    .bias_valid(bias_valid),
    .bias      (bias),
    .h_valid   (h_valid),
    .h         (h)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Checks and run end
  ////////////////////////////////////////////////////////////

  task automatic check_hidden(input ntm_hidden_t actual, input ntm_hidden_t expected);
    if (actual.value !== expected.value) begin
      value_errors++;
      $display("mismatch h.value: got %h expected %h", actual.value, expected.value);
    end
    if (actual.index !== expected.index) begin
      value_errors++;
      $display("mismatch h.index: got %h expected %h", actual.index, expected.index);
    end
  endtask

  task automatic check_latency(input int actual, input int expected);
    if (actual != expected) begin
      timing_errors++;
      $display("mismatch h_valid cycle: got %h expected %h", actual, expected);
    end
  endtask

  task automatic finish_run();
    if (expect_q.size() != 0) begin
      other_errors += expect_q.size();
      $display("error: %0d expected outputs never arrived", expect_q.size());
    end
    $display("errors: value %0d, timing %0d, other %0d",
             value_errors, timing_errors, other_errors);
    if (value_errors + timing_errors + other_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  // Cycle count for latency checks and the run limit
  always @(posedge CLK) begin
    cycle = cycle + 1;
    if (cycle >= cycle_limit) begin
      other_errors++;
      $display("error: timeout after %0d cycles", cycle);
      finish_run();
    end
  end

  // Outputs sampled mid-cycle away from the clock edge
  always @(negedge CLK) begin : monitor
    ntm_hidden_t exp_h;
    int          exp_cycle;
    if (h_valid) begin
      if (expect_q.size() == 0) begin
        other_errors++;
        $display("error: output at cycle %0d with no expected value queued", cycle);
      end else begin
        exp_h = expect_q.pop_front();
        check_hidden(h, exp_h);
      end
      if (last_cycle_q.size() == 0) begin
        other_errors++;
        $display("error: output at cycle %0d without a completed neuron", cycle);
      end else begin
        exp_cycle = last_cycle_q.pop_front() + 3;
        check_latency(cycle, exp_cycle);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////////////////////////

  task automatic store_command(input byte kind, input int got, input int want,
                               input logic [31:0] a0, input logic [31:0] a1,
                               input logic [31:0] a2, input logic [31:0] a3);
    if (got != want) begin
      other_errors++;
      $display("error: stimulus line %0d has a malformed %c command", n_lines, kind);
    end else begin
      cmd_q.push_back(kind);
      arg0_q.push_back(a0);
      arg1_q.push_back(a1);
      arg2_q.push_back(a2);
      arg3_q.push_back(a3);
    end
  endtask

  task automatic load_stimulus(input int fd);
    logic [63:0]    tok;
    logic [2047:0]  rest;
    logic [31:0]    a0;
    logic [31:0]    a1;
    logic [31:0]    a2;
    logic [31:0]    a3;
    int             code;
    bit             done;
    done = 1'b0;
    while (!done) begin
      tok  = '0;
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        done = 1'b1;
      end else begin
        n_lines++;
        case (tok)
          "#": code = $fgets(rest, fd);
          "B": begin
            code = $fscanf(fd, "%h", a0);
            store_command("B", code, 1, a0, '0, '0, '0);
          end
          "T": begin
            code = $fscanf(fd, "%h %h %d %d", a0, a1, a2, a3);
            store_command("T", code, 4, a0, a1, a2, a3);
          end
          "I": begin
            code = $fscanf(fd, "%d", a0);
            store_command("I", code, 1, a0, '0, '0, '0);
            idle_total += a0;
          end
          "R": store_command("R", 1, 1, '0, '0, '0, '0);
          "E": begin
            code = $fscanf(fd, "%h %h", a0, a1);
            store_command("E", code, 2, a0, a1, '0, '0);
          end
          default: begin
            other_errors++;
            $display("error: unknown command on stimulus line %0d", n_lines);
            code = $fgets(rest, fd);
          end
        endcase
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Drivers 1 ns after the rising edge
  ////////////////////////////////////////////////////////////

  // Staged bias goes out once and then the strobe drops
  task automatic apply_bias();
    bias_valid      = pend_bias_valid;
    bias            = pend_bias_valid ? pend_bias : '0;
    pend_bias_valid = 1'b0;
  endtask

  task automatic drive_idle();
    @(posedge CLK);
    #1;
    term_valid = 1'b0;
    term       = '0;
    apply_bias();
  endtask

  task automatic drive_term(input data_t weight, input data_t operand,
                            input logic first, input logic last);
    @(posedge CLK);
    #1;
    term_valid   = 1'b1;
    term.weight  = weight;
    term.operand = operand;
    term.first   = first;
    term.last    = last;
    apply_bias();
    // First opens a neuron and last closes only an open one
    if (first) begin
      frame_open = 1'b1;
    end
    if (frame_open && last) begin
      last_cycle_q.push_back(cycle);
      frame_open = 1'b0;
    end
  endtask

  task automatic pulse_reset();
    @(posedge CLK);
    #1;
    RST             = 1'b1;
    term_valid      = 1'b0;
    bias_valid      = 1'b0;
    pend_bias_valid = 1'b0;
    frame_open      = 1'b0;
    @(posedge CLK);
    #1;
    RST = 1'b0;
  endtask

  task automatic run_stimulus();
    ntm_hidden_t e;
    for (int i = 0; i < cmd_q.size(); i++) begin
      case (cmd_q[i])
        "B": begin
          pend_bias_valid = 1'b1;
          pend_bias       = data_t'(arg0_q[i]);
        end
        "T": drive_term(data_t'(arg0_q[i]), data_t'(arg1_q[i]), arg2_q[i][0], arg3_q[i][0]);
        "I": repeat (arg0_q[i]) drive_idle();
        "R": pulse_reset();
        "E": begin
          e.index = index_t'(arg0_q[i]);
          e.value = data_t'(arg1_q[i]);
          expect_q.push_back(e);
        end
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    int fd;
    RST             = 1'b1;
    term_valid      = 1'b0;
    term            = '0;
    bias_valid      = 1'b0;
    bias            = '0;
    pend_bias_valid = 1'b0;
    pend_bias       = '0;
    frame_open      = 1'b0;
    fd = $fopen("bench/ntm_stimulus.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("error: cannot open bench/ntm_stimulus.txt");
      finish_run();
    end else begin
      load_stimulus(fd);
      $fclose(fd);
      cycle_limit = n_lines + idle_total + 20;
      repeat (RESET_CYCLES) @(posedge CLK);
      #1;
      RST = 1'b0;
      run_stimulus();
      drive_idle();
      // Wait for all outputs and then a quiet window longer than the 3-cycle latency
      while (expect_q.size() != 0) @(posedge CLK);
      repeat (4) @(posedge CLK);
      finish_run();
    end
  end

endmodule

// File: bench/ntm_stimulus.txt
# Commands: B bias | T weight operand first last | I idle_cycles | R | E index value
# Bias, weight, operand, index and value in hex (Q8.8); flags and idle counts decimal
#
# Single term neuron, first and last together, bias 0.25
B 0040
T 0100 0080 1 1
E 00 00b0
I 2
#
# Multi-term neuron, W*x and K*r terms with negative operands, bias -0.0625
B fff0
T 0180 ff40 1 0
T 0033 0100 0 0
T ffa0 ff9b 0 0
T 0025 fff7 0 1
E 01 0049
# Bias loaded in an idle cycle ahead of the neuron
B 0020
I 1
T 0200 0013 1 0
T fe80 0021 0 0
T 0011 fffd 0 1
E 02 0084
I 3
#
# Saturation, one neuron per cycle, bias 0
B 0000
T 0200 0200 1 1
E 03 0100
T 0100 0200 1 1
E 04 0100
T 0100 01ff 1 1
E 05 00ff
T fe00 0200 1 1
E 06 0000
T 0100 fe00 1 1
E 07 0000
T 0100 fe04 1 1
E 08 0001
#
# Back to back neurons, bias loaded with first term
B 0100
T 0040 0100 1 0
T 0010 0100 0 1
E 09 00d4
B ff00
T 0080 0100 1 1
E 0a 0060
T 0100 0040 1 0
# Bias in mid-neuron applies only to the next neuron
B 0080
T 0100 0020 0 0
T 0100 0010 0 1
E 0b 005c
T 0040 0040 1 1
E 0c 00a4
I 3
#
# First flag in mid-neuron discards the partial sum
T 0100 0100 1 0
T 0100 0100 0 0
T 0100 0040 1 0
T 0100 0020 0 1
E 0d 00b8
# Stray terms outside any neuron are ignored
T 0100 0100 0 0
T 0100 0100 0 1
I 5
#
# Reset in mid-neuron clears bias and index
B 0100
T 0100 0100 1 0
T 0100 0100 0 0
R
T 0100 0100 0 1
T 0100 0080 1 1
E 00 00a0
T 0300 ff00 1 0
T 0100 0200 0 1
E 01 0040
I 6

// File: files.f
src/ntm_pkg.sv
src/ntm_term_multiplier.sv
src/ntm_neuron_accumulator.sv
src/ntm_logistic.sv
src/ntm_controller.sv
bench/ntm_controller_tb.sv

// File: src/ntm_controller.sv
// Hidden layer of the NTM controller as a three-stage pipeline
// Neuron framing comes only from the first/last flags of the term stream
// h_valid follows the last term of a neuron by exactly 3 cycles
// No back-pressure, terms may arrive every cycle

`timescale 1ns/1ps

module ntm_controller
  import ntm_pkg::*;
#(
  parameter int FRAC_BITS = 8
) (
  input  logic        CLK,
  input  logic        RST,

  // W*x and K*r terms
  input  logic        term_valid,
  input  ntm_term_t   term,

  // Bias b(l)
  input  logic        bias_valid,
  input  data_t       bias,

  // Hidden output h(l)
  output logic        h_valid,
  output ntm_hidden_t h
);

  ////////////////////////////////////////////////////////////
  // Stage links
  ////////////////////////////////////////////////////////////

  logic         product_valid;
  ntm_product_t product;

  logic         sum_valid;
  ntm_sum_t     sum;

  ////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////

  // Stage 1, term products
  ntm_term_multiplier #(
    .FRAC_BITS(FRAC_BITS)
  ) i_ntm_term_multiplier (
    .CLK          (CLK),
    .RST          (RST),
    .term_valid   (term_valid),
    .term         (term),
    .product_valid(product_valid),
    .product      (product)
  );

  // Stage 2, per-neuron sum plus bias
  ntm_neuron_accumulator i_ntm_neuron_accumulator (
    .CLK          (CLK),
    .RST          (RST),
    .bias_valid   (bias_valid),
    .bias         (bias),
    .product_valid(product_valid),
    .product      (product),
    .sum_valid    (sum_valid),
    .sum          (sum)
  );

  // Stage 3, activation
  ntm_logistic #(
    .FRAC_BITS(FRAC_BITS)
  ) i_ntm_logistic (
    .CLK      (CLK),
    .RST      (RST),
    .sum_valid(sum_valid),
    .sum      (sum),
    .h_valid  (h_valid),
    .h        (h)
  );

endmodule

// File: src/ntm_logistic.sv
// Stage 3, hard sigmoid h = 0.5 + x/4 clipped to [0, 1]
// Input sum is Q8.8 in 32 bits, output is Q8.8 in 16 bits
// Saturates high from sum 2.0, low once 0.5 + x/4 reaches 0

`timescale 1ns/1ps

module ntm_logistic
  import ntm_pkg::*;
#(
  parameter int FRAC_BITS = 8
) (
  input  logic        CLK,
  input  logic        RST,

  // Sum stream in
  input  logic        sum_valid,
  input  ntm_sum_t    sum,

  // Hidden output
  output logic        h_valid,
  output ntm_hidden_t h
);

  ////////////////////////////////////////////////////////////
  // Constants and signals
  ////////////////////////////////////////////////////////////

  // Sum of 2.0 maps onto 1.0
  localparam acc_t SAT_HI = acc_t'(2) <<< FRAC_BITS;

  acc_t  linear;
  data_t h_next;

  ////////////////////////////////////////////////////////////
  // Hard sigmoid
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Slope of 1/4, floor rounding
    linear = acc_t'(HALF_Q) + (sum.value >>> 2);
    if (sum.value >= SAT_HI) begin
      h_next = ONE_Q;
    end else if (linear <= 0) begin
      h_next = '0;
    end else begin
      // Between 0 and 1 here, fits in 16 bits
      h_next = data_t'(linear);
    end
  end

  // Valid strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      h_valid <= 1'b0;
    end else begin
      h_valid <= sum_valid;
    end
  end

  // Result with neuron index
  always_ff @(posedge CLK) begin
    if (sum_valid) begin
      h.value <= h_next;
      h.index <= sum.index;
    end
  end

endmodule

// File: src/ntm_neuron_accumulator.sv
// Stage 2, sums the products of one neuron and adds its bias
// Bias is sampled from the register as it stands when the first product arrives,
// i.e. the latest bias presented up to the cycle of the first term
// Products are already Q8.8, so the bias is only sign-extended
// Sum wraps modulo 2^32, neuron index wraps at 256

`timescale 1ns/1ps

module ntm_neuron_accumulator
  import ntm_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,

  // Bias load
  input  logic         bias_valid,
  input  data_t        bias,

  // Product stream in
  input  logic         product_valid,
  input  ntm_product_t product,

  // Completed sums out
  output logic         sum_valid,
  output ntm_sum_t     sum
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  data_t  bias_q;     // current bias
  acc_t   run_sum;    // partial sum of current neuron
  logic   active;     // inside a neuron
  index_t index_q;    // number of next neuron to emit

  logic   accept;
  logic   close;
  acc_t   base;
  acc_t   next_sum;

  ////////////////////////////////////////////////////////////
  // Summing
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Products before any first flag are dropped
    accept   = product_valid && (product.first || active);
    close    = accept && product.last;
    // First product restarts from the bias, discarding any partial sum
    base     = product.first ? acc_t'(bias_q) : run_sum;
    next_sum = base + product.value;
  end

  ////////////////////////////////////////////////////////////
  // Control state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      bias_q    <= '0;
      active    <= 1'b0;
      index_q   <= '0;
      sum_valid <= 1'b0;
    end else begin
      if (bias_valid) begin
        bias_q <= bias;
      end
      sum_valid <= close;
      if (accept) begin
        active <= !product.last;
      end
      if (close) begin
        index_q <= index_q + 1'b1;
      end
    end
  end

  // Running sum and output payload
  always_ff @(posedge CLK) begin
    if (accept) begin
      run_sum <= next_sum;
    end
    if (close) begin
      sum.value <= next_sum;
      sum.index <= index_q;
    end
  end

endmodule

// File: src/ntm_pkg.sv
// Shared types for the NTM controller hidden-layer datapath
// All data values are signed Q8.8; products and sums are kept in 32 bits

package ntm_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int DATA_W  = 16;
  localparam int ACC_W   = 32;
  localparam int INDEX_W = 8;

  ////////////////////////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////////////////////////

  typedef logic signed [DATA_W-1:0]  data_t;
  typedef logic signed [ACC_W-1:0]   acc_t;
  typedef logic        [INDEX_W-1:0] index_t;

  // Q8.8 landmarks of the hard sigmoid
  localparam data_t ONE_Q  = 16'sh0100;
  localparam data_t HALF_Q = 16'sh0080;

  ////////////////////////////////////////////////////////////
  // Pipeline payloads
  ////////////////////////////////////////////////////////////

  // One W*x or K*r term framed by first/last
  typedef struct packed {
    data_t weight;
    data_t operand;
    logic  first;
    logic  last;
  } ntm_term_t;

  // Rescaled product with its flags carried along
  typedef struct packed {
    acc_t value;
    logic first;
    logic last;
  } ntm_product_t;

  // Finished pre-activation of one neuron
  typedef struct packed {
    acc_t   value;
    index_t index;
  } ntm_sum_t;

  // Hidden output h(l)
  typedef struct packed {
    data_t  value;
    index_t index;
  } ntm_hidden_t;

endpackage

// File: src/ntm_term_multiplier.sv
// Stage 1 of the hidden-layer pipeline, one term per cycle, no stall
// Product is rescaled by FRAC_BITS with floor rounding (arithmetic shift)
// Result appears one cycle after the term

`timescale 1ns/1ps

module ntm_term_multiplier
  import ntm_pkg::*;
#(
  parameter int FRAC_BITS = 8
) (
  input  logic         CLK,
  input  logic         RST,

  // Term stream in
  input  logic         term_valid,
  input  ntm_term_t    term,

  // Product stream out
  output logic         product_valid,
  output ntm_product_t product
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  acc_t full_product;
  acc_t scaled_product;

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  // Q8.8 x Q8.8 gives Q16.16 in 32 bits, never overflows
  always_comb begin
    full_product   = term.weight * term.operand;
    // Back to Q8.8 scale, truncating toward minus infinity
    scaled_product = full_product >>> FRAC_BITS;
  end

  // Valid strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      product_valid <= 1'b0;
    end else begin
      product_valid <= term_valid;
    end
  end

  // Payload with framing flags
  always_ff @(posedge CLK) begin
    if (term_valid) begin
      product.value <= scaled_product;
      product.first <= term.first;
      product.last  <= term.last;
    end
  end

endmodule
